//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int addr_bits   = 64;
	localparam int num_ways    = 4;
	localparam int num_sets    = 64;
	localparam int offset_bits = 4;                                // 16-byte lines
	localparam int index_bits  = 6;
	localparam int tag_bits    = addr_bits - index_bits - offset_bits; // 54 bits

	typedef logic [tag_bits-1:0]   tag_t;
	typedef logic [index_bits-1:0] index_t;
	typedef logic [num_ways-1:0]   way_mask_t;  // one-hot or empty

	// how a byte address splits up for the cache
	typedef struct packed {
		tag_t                   tag;
		index_t                 index;
		logic [offset_bits-1:0] offset;
	} cache_addr_t;

	// the request as the load/store stage holds it while valid is high
	typedef struct packed {
		logic [addr_bits-1:0] addr;
		logic                 wren;
		logic [63:0]          din;
		logic [63:0]          mask;  // bit mask, not byte mask
	} cache_req_t;

	typedef struct packed {
		logic [31:0] read_hits;
		logic [31:0] read_misses;
		logic [31:0] write_hits;
		logic [31:0] write_misses;
	} perf_counts_t;

endpackage

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int line_bits        = 128;
	localparam int line_offset_bits = 4;
	localparam int mem_depth        = 1024;             // lines in the backing store
	localparam int mem_line_bits    = $clog2(mem_depth); // line number is addr[13:4]

	// everything at or above this goes straight to memory
	localparam logic [63:0] device_base = 64'h9000_0000;

	typedef logic [line_bits-1:0] line_t;

	// one 64-bit word write, the half of the line comes from addr bit 3
	typedef struct packed {
		logic        strobe;
		logic [63:0] addr;
		logic [63:0] data;
		logic [63:0] mask;
	} mem_write_t;

endpackage

`default_nettype wire

//--- verilog/dcache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array
	import cache_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire index_t     index,
	input  wire tag_t       tag,
	output way_mask_t       hit_ways,
	input  wire             alloc_en,
	input  wire way_mask_t  alloc_ways
);

	tag_t                tags [num_ways][num_sets];
	logic [num_sets-1:0] valid_bits [num_ways];

	// a way hits when its entry for this set is live and holds the same tag
	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			hit_ways[w] = valid_bits[w][index] && (tags[w][index] == tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < num_ways; w++) begin
				valid_bits[w] <= '0;
			end
		end else if (alloc_en) begin
			for (int w = 0; w < num_ways; w++) begin
				if (alloc_ways[w]) begin
					valid_bits[w][index] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_en) begin
			for (int w = 0; w < num_ways; w++) begin
				if (alloc_ways[w]) begin
					tags[w][index] <= tag;  // the tag being looked up is the one installed
				end
			end
		end
	end

	// control only allocates on a miss, so a line never lives in two ways
	assert property (@(posedge clk) disable iff (rst) $onehot0(hit_ways))
		else $error("tag array: more than one way hit, hit_ways=%b", hit_ways);

	assert property (@(posedge clk) disable iff (rst) alloc_en |-> $onehot(alloc_ways))
		else $error("tag array: allocation into %b is not one-hot", alloc_ways);

endmodule

`default_nettype wire

//--- verilog/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array
	import cache_pkg::*, mem_pkg::*;
(
	input  wire             clk,
	input  wire index_t     index,
	input  wire way_mask_t  way_en,
	input  wire             write_en,
	input  wire line_t      write_line,
	input  wire line_t      write_mask,  // set bits are replaced
	output line_t           read_lines [num_ways]
);

	line_t store [num_ways][num_sets];

	// each way is a single-port store: the read returns the old contents
	always_ff @(posedge clk) begin
		for (int w = 0; w < num_ways; w++) begin
			if (way_en[w]) begin
				read_lines[w] <= store[w][index];
				if (write_en) begin
					store[w][index] <= (store[w][index] & ~write_mask)
						| (write_line & write_mask);
				end
			end
		end
	end

	// the read data mux downstream picks one way by the registered hit mask
	assert property (@(posedge clk) $onehot0(way_en))
		else $error("data array: more than one way enabled, way_en=%b", way_en);

endmodule

`default_nettype wire

//--- verilog/dcache_control.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_control
	import cache_pkg::*, mem_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire              valid,
	input  wire cache_req_t  req,
	output logic             ready,
	output logic [63:0]      dout,
	output perf_counts_t     perf,
	input  wire line_t       mem_line,
	output mem_write_t       mem_wr,
	output index_t           index,
	output tag_t             tag,
	input  wire way_mask_t   hit_ways,
	output logic             alloc_en,
	output way_mask_t        alloc_ways,
	output way_mask_t        way_en,
	output logic             write_en,
	output line_t            write_line,
	output line_t            write_mask,
	input  wire line_t       read_lines [num_ways]
);

	cache_addr_t fields;
	logic        lookup;
	logic        cacheable;
	logic        hit;
	way_mask_t   victim;
	way_mask_t   hit_prev;
	line_t       line_prev;
	line_t       line_read;
	line_t       half_data;
	line_t       half_mask;
	line_t       merged;

	assign fields    = req.addr;
	assign index     = fields.index;
	assign tag       = fields.tag;
	assign lookup    = valid && !ready;          // first cycle of every access
	assign cacheable = req.addr < device_base;
	assign hit       = |hit_ways;

	// din and mask placed into the half of the line that addr bit 3 selects
	assign half_data = req.addr[3] ? {req.din, 64'b0} : {64'b0, req.din};
	assign half_mask = req.addr[3] ? {req.mask, 64'b0} : {64'b0, req.mask};
	assign merged    = (mem_line & ~half_mask) | (half_data & half_mask);

	// a hit uses its own way, a miss fills the victim
	assign way_en     = (lookup && cacheable) ? (hit ? hit_ways : victim) : '0;
	assign write_en   = lookup && cacheable && (req.wren || !hit);
	assign write_line = !req.wren ? mem_line : (hit ? half_data : merged);
	assign write_mask = (req.wren && hit) ? half_mask : '1;
	assign alloc_en   = lookup && cacheable && !hit;
	assign alloc_ways = victim;

	// every store reaches memory whether or not its line is cached
	always_comb begin
		mem_wr.strobe = lookup && req.wren;
		mem_wr.addr   = req.addr;
		mem_wr.data   = req.din;
		mem_wr.mask   = req.mask;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ready    <= 1'b0;
			hit_prev <= '0;
			victim   <= way_mask_t'(1);
			perf     <= '0;
		end else begin
			ready <= lookup;  // pulses for one cycle while the request is still held
			if (lookup) begin
				hit_prev <= cacheable ? hit_ways : '0;
				victim   <= {victim[num_ways-2:0], victim[num_ways-1]};
				if (cacheable) begin
					case ({req.wren, hit})
						2'b00: perf.read_misses  <= perf.read_misses + 32'd1;
						2'b01: perf.read_hits    <= perf.read_hits + 32'd1;
						2'b10: perf.write_misses <= perf.write_misses + 32'd1;
						default: perf.write_hits <= perf.write_hits + 32'd1;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lookup) begin
			line_prev <= mem_line;  // memory line as it was before this access wrote it
		end
	end

	// misses and device reads answer from the captured memory line
	always_comb begin
		line_read = line_prev;
		for (int w = 0; w < num_ways; w++) begin
			if (hit_prev[w]) begin
				line_read = read_lines[w];
			end
		end
	end

	assign dout = req.addr[3] ? line_read[127:64] : line_read[63:0];

	// dout takes its half from req.addr, which must still be held in the ready cycle
	assert property (@(posedge clk) disable iff (rst) lookup |=> valid && $stable(req))
		else $error("control: request changed or dropped before its ready cycle");

endmodule

`default_nettype wire

//--- verilog/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory
	import mem_pkg::*;
(
	input  wire               clk,
	input  wire               rst,
	input  wire [63:0]        addr,
	output line_t             line,
	input  wire mem_write_t   wr
);

	line_t                    lines [mem_depth];
	logic [mem_line_bits-1:0] rd_line;
	logic [mem_line_bits-1:0] wr_line;
	logic [63:0]              old_word;
	logic [63:0]              new_word;

	// upper address bits alias, the store is only 16 KiB
	assign rd_line = addr[line_offset_bits +: mem_line_bits];
	assign wr_line = wr.addr[line_offset_bits +: mem_line_bits];

	assign line = lines[rd_line];

	assign old_word = wr.addr[3] ? lines[wr_line][127:64] : lines[wr_line][63:0];
	assign new_word = (old_word & ~wr.mask) | (wr.data & wr.mask);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < mem_depth; i++) begin
				lines[i] <= '0;
			end
		end else if (wr.strobe) begin
			if (wr.addr[3]) begin
				lines[wr_line][127:64] <= new_word;
			end else begin
				lines[wr_line][63:0] <= new_word;
			end
		end
	end

	// a store issued during reset would be lost to the clear
	assert property (@(posedge clk) rst |-> !wr.strobe)
		else $error("main memory: write strobe during reset, addr=%h", wr.addr);

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
	import cache_pkg::*, mem_pkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire              valid,
	input  wire cache_req_t  req,
	output logic             ready,
	output logic [63:0]      dout,
	output perf_counts_t     perf
);

	index_t     index;
	tag_t       tag;
	way_mask_t  hit_ways;
	logic       alloc_en;
	way_mask_t  alloc_ways;
	way_mask_t  way_en;
	logic       write_en;
	line_t      write_line;
	line_t      write_mask;
	line_t      read_lines [num_ways];
	line_t      mem_line;
	mem_write_t mem_wr;

	dcache_control i_control (
		.clk        (clk),
		.rst        (rst),
		.valid      (valid),
		.req        (req),
		.ready      (ready),
		.dout       (dout),
		.perf       (perf),
		.mem_line   (mem_line),
		.mem_wr     (mem_wr),
		.index      (index),
		.tag        (tag),
		.hit_ways   (hit_ways),
		.alloc_en   (alloc_en),
		.alloc_ways (alloc_ways),
		.way_en     (way_en),
		.write_en   (write_en),
		.write_line (write_line),
		.write_mask (write_mask),
		.read_lines (read_lines)
	);

	dcache_tag_array i_tag_array (
		.clk        (clk),
		.rst        (rst),
		.index      (index),
		.tag        (tag),
		.hit_ways   (hit_ways),
		.alloc_en   (alloc_en),
		.alloc_ways (alloc_ways)
	);

	dcache_data_array i_data_array (
		.clk        (clk),
		.index      (index),
		.way_en     (way_en),
		.write_en   (write_en),
		.write_line (write_line),
		.write_mask (write_mask),
		.read_lines (read_lines)
	);

	main_memory i_memory (
		.clk  (clk),
		.rst  (rst),
		.addr (req.addr),  // line for the current request, read every cycle
		.line (mem_line),
		.wr   (mem_wr)
	);

endmodule

`default_nettype wire

//--- testbench/tb_dcache_cases.svh
`ifndef tb_dcache_cases_svh
`define tb_dcache_cases_svh

typedef enum logic [2:0] {
	cls_read_hit,
	cls_read_miss,
	cls_write_hit,
	cls_write_miss,
	cls_uncached
} access_class_t;

typedef struct packed {
	cache_req_t    req;
	access_class_t cls;
} test_case_t;

localparam int num_cases = 19;

test_case_t cases [num_cases];
int         case_fill;

function automatic void add_case(input logic [63:0] addr, input logic wren,
		input logic [63:0] din, input logic [63:0] mask, input access_class_t cls);
	cases[case_fill].req = '{addr: addr, wren: wren, din: din, mask: mask};
	cases[case_fill].cls = cls;
	case_fill++;
endfunction

// sets 0x10, 0x24 and 0x3f; 0x100 and 0x500 share set 0x10 in different ways
function automatic void load_cases();
	case_fill = 0;
	add_case(64'h100, 1'b0, 64'h0, 64'h0, cls_read_miss);
	add_case(64'h100, 1'b0, 64'h0, 64'h0, cls_read_hit);
	add_case(64'h108, 1'b0, 64'h0, 64'h0, cls_read_hit);       // other half of the same line
	add_case(64'h108, 1'b1, 64'h1122_3344_5566_7788, 64'h0000_0000_ffff_ffff, cls_write_hit);
	add_case(64'h108, 1'b0, 64'h0, 64'h0, cls_read_hit);
	add_case(64'h240, 1'b1, 64'hdead_beef_cafe_f00d, 64'hffff_ffff_ffff_ffff, cls_write_miss);
	add_case(64'h240, 1'b0, 64'h0, 64'h0, cls_read_hit);
	add_case(64'h248, 1'b1, 64'ha5a5_5a5a_0f0f_f0f0, 64'hff00_ff00_ff00_ff00, cls_write_hit);
	add_case(64'h248, 1'b0, 64'h0, 64'h0, cls_read_hit);
	add_case(64'h9000_2010, 1'b1, 64'h0123_4567_89ab_cdef, 64'hffff_ffff_ffff_ffff,
		cls_uncached);
	add_case(64'h9000_2010, 1'b0, 64'h0, 64'h0, cls_uncached);
	add_case(64'h9000_2018, 1'b1, 64'h7777_8888_9999_aaaa, 64'h0000_ffff_0000_ffff,
		cls_uncached);
	add_case(64'h9000_2018, 1'b0, 64'h0, 64'h0, cls_uncached);
	add_case(64'h500, 1'b0, 64'h0, 64'h0, cls_read_miss);
	add_case(64'h500, 1'b0, 64'h0, 64'h0, cls_read_hit);
	add_case(64'h108, 1'b0, 64'h0, 64'h0, cls_read_hit);       // still resident in way 0
	add_case(64'h3f8, 1'b1, 64'h0bad_f00d_1234_5678, 64'hffff_ffff_0000_0000, cls_write_miss);
	add_case(64'h3f8, 1'b0, 64'h0, 64'h0, cls_read_hit);
	add_case(64'h3f0, 1'b0, 64'h0, 64'h0, cls_read_hit);
endfunction

function automatic string class_name(input access_class_t cls);
	case (cls)
		cls_read_hit:   return "read hit";
		cls_read_miss:  return "read miss";
		cls_write_hit:  return "write hit";
		cls_write_miss: return "write miss";
		default:        return "uncached";
	endcase
endfunction

`endif

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
	import cache_pkg::*;
();

	`include "tb_dcache_cases.svh"

	localparam int num_random  = 200;
	localparam int ready_limit = 8;  // cycles to wait for ready before giving up on an access
	localparam int watchdog_ns = (num_cases + num_random) * 4 * 10 + 200;
	localparam logic [63:0] device_window = 64'h9000_2000;  // memory lines 512..767

	logic         clk;
	logic         rst;
	logic         valid;
	cache_req_t   req;
	logic         ready;
	logic [63:0]  dout;
	perf_counts_t perf;

	logic [63:0]  ref_mem [2048];  // one entry per 64-bit word of main memory
	perf_counts_t exp_perf;
	logic [31:0]  lcg_state;
	int           errors;
	int           checks;
	int           tests;
	int           failed_tests;
	int           cacheable_count;

	dcache_top i_dut (
		.clk   (clk),
		.rst   (rst),
		.valid (valid),
		.req   (req),
		.ready (ready),
		.dout  (dout),
		.perf  (perf)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// memory keeps the unmasked bits of the addressed word
	function automatic void model_write(input cache_req_t r);
		if (r.wren)
			ref_mem[r.addr[13:3]] = (ref_mem[r.addr[13:3]] & ~r.mask) | (r.din & r.mask);
	endfunction

	function automatic void count_expected(input access_class_t cls);
		case (cls)
			cls_read_hit:   exp_perf.read_hits    = exp_perf.read_hits + 32'd1;
			cls_read_miss:  exp_perf.read_misses  = exp_perf.read_misses + 32'd1;
			cls_write_hit:  exp_perf.write_hits   = exp_perf.write_hits + 32'd1;
			cls_write_miss: exp_perf.write_misses = exp_perf.write_misses + 32'd1;
			default:        ;
		endcase
		if (cls != cls_uncached)
			cacheable_count++;
	endfunction

	task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_perf(input perf_counts_t got, input perf_counts_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			if (got.read_hits !== exp.read_hits)
				$display("Fail perf.read_hits: got %h, expected %h", got.read_hits, exp.read_hits);
			if (got.read_misses !== exp.read_misses)
				$display("Fail perf.read_misses: got %h, expected %h", got.read_misses,
					exp.read_misses);
			if (got.write_hits !== exp.write_hits)
				$display("Fail perf.write_hits: got %h, expected %h", got.write_hits,
					exp.write_hits);
			if (got.write_misses !== exp.write_misses)
				$display("Fail perf.write_misses: got %h, expected %h", got.write_misses,
					exp.write_misses);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	// called just after a rising edge; returns just after the edge where ready falls
	task automatic do_access(input cache_req_t r, output logic [63:0] data);
		int waits;
		waits = 0;
		req   = r;
		valid = 1'b1;
		@(negedge clk);
		while (!ready && waits < ready_limit) begin
			waits++;
			@(negedge clk);
		end
		data = dout;  // dout only holds the answer in the ready cycle
		if (!ready) begin
			errors++;
			$display("no ready within %0d cycles for address %h", ready_limit, r.addr);
		end else if (waits != 1) begin
			errors++;
			$display("ready came %0d cycles after valid instead of 1, address %h", waits, r.addr);
		end
		@(posedge clk);
		#1;
		if (ready) begin
			errors++;
			$display("ready stayed high for more than one cycle, address %h", r.addr);
		end
	endtask

	initial begin
		cache_req_t  rq;
		logic [63:0] got;
		logic [63:0] exp;
		logic [31:0] r;
		logic [63:0] perf_sum;
		int          errors_before;

		clk   = 1'b0;
		rst   = 1'b1;
		valid = 1'b0;
		req   = '0;
		exp_perf        = '0;
		lcg_state       = 32'hd482;
		errors          = 0;
		checks          = 0;
		tests           = 0;
		failed_tests    = 0;
		cacheable_count = 0;
		for (int i = 0; i < 2048; i++) begin
			ref_mem[i] = 64'h0;
		end
		load_cases();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		errors_before = errors;
		repeat (3) begin
			@(negedge clk);
			check_data("ready", {63'b0, ready}, 64'h0);
			check_perf(perf, exp_perf);
		end
		report_test("reset idle", errors_before);
		@(posedge clk);
		#1;

		for (int i = 0; i < num_cases; i++) begin
			errors_before = errors;
			exp = ref_mem[cases[i].req.addr[13:3]];
			do_access(cases[i].req, got);
			if (!cases[i].req.wren)
				check_data("dout", got, exp);
			count_expected(cases[i].cls);
			check_perf(perf, exp_perf);
			model_write(cases[i].req);
			report_test($sformatf("case %0d %s at %h", i, class_name(cases[i].cls),
				cases[i].req.addr), errors_before);
		end

		// a quarter of the random requests go to the device window
		errors_before = errors;
		for (int n = 0; n < num_random; n++) begin
			r       = lcg_next();
			rq.wren = r[31];
			rq.addr = {52'b0, r[27:19], 3'b000};
			if (r[30:29] == 2'b00)
				rq.addr = rq.addr + device_window;
			else
				cacheable_count++;
			rq.din  = {lcg_next(), lcg_next()};
			rq.mask = {lcg_next(), lcg_next()};
			exp = ref_mem[rq.addr[13:3]];
			do_access(rq, got);
			if (!rq.wren)
				check_data("dout", got, exp);
			model_write(rq);
		end
		valid = 1'b0;
		perf_sum = 64'(perf.read_hits) + perf.read_misses + perf.write_hits + perf.write_misses;
		check_data("perf sum", perf_sum, 64'(cacheable_count));
		report_test($sformatf("random run of %0d requests", num_random), errors_before);

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog: the run did not finish within %0d ns, the DUT seems to hang",
			watchdog_ns);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dcache_top.f
+incdir+testbench
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_control.sv
verilog/main_memory.sv
verilog/dcache_top.sv
testbench/tb_dcache.sv
